// File: verilog.f
design/pcm_pkg.sv
design/pcm_apb_regs.sv
design/pcm_sample_fifo.sv
design/pcm_interpol.sv
design/pcm_uprate.sv
design/pcm_dac_top.sv
testbench/tb_pcm_dac.sv

// File: run.sh
#!/bin/sh
# build the pcm dac testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_pcm_dac -f verilog.f \
    -o sim_pcm_dac || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/sim_pcm_dac)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/tb_pcm_dac.sv
`timescale 1ns/10ps

module tb_pcm_dac;

    // total data register writes, sizes the watchdog
    localparam int n_samples = 40;
    localparam int max_cycles = n_samples * 24 + 2000;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    pcm_pkg::apb_addr_t   paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 zero = 1'b0;
    pcm_pkg::pcm_sample_t pcm_resampled;

    // zero pulse generator
    logic zero_pause;
    int   tick_cnt = 0;

    // sample model
    pcm_pkg::pcm_sample_t sample_q [$];
    pcm_pkg::pcm_sample_t prev_model;
    pcm_pkg::pcm_sample_t cur_model;
    pcm_pkg::pcm_sample_t held_model;
    logic [7:0]           uf_model;
    logic                 zero_q;
    int                   edge_cnt;
    int                   delay_cnt;
    // seen by the assertions one clock later
    logic                 en_model;
    logic                 chk_out;
    pcm_pkg::pcm_sample_t exp_out;
    logic [31:0]          exp_rd;
    int                   lvl_model;

    int          value_errs = 0;
    int          protocol_errs = 0;
    logic        unmapped;

    always #2 clk = ~clk;

    pcm_dac_top dut0 (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .psel          ( psel          ),
        .penable       ( penable       ),
        .pwrite        ( pwrite        ),
        .paddr         ( paddr         ),
        .pwdata        ( pwdata        ),
        .prdata        ( prdata        ),
        .pready        ( pready        ),
        .pslverr       ( pslverr       ),
        .zero          ( zero          ),
        .pcm_resampled ( pcm_resampled )
    );

    assign unmapped = (paddr != pcm_pkg::addr_ctrl) && (paddr != pcm_pkg::addr_data) &&
                      (paddr != pcm_pkg::addr_status);

    // midpoint of two samples, floor of the half sum
    function automatic pcm_pkg::pcm_sample_t midpoint(pcm_pkg::pcm_sample_t a,
                                                      pcm_pkg::pcm_sample_t b);
        int s;
        s = int'(a) + int'(b);
        return pcm_pkg::pcm_sample_t'(s >>> 1);
    endfunction

    // register map as seen by a read
    function automatic logic [31:0] read_value(pcm_pkg::apb_addr_t a, logic en, int lvl,
                                               logic [7:0] uf);
        logic [31:0] v;
        v = 32'd0;
        if (a == pcm_pkg::addr_ctrl) begin
            v[0] = en;
        end else if (a == pcm_pkg::addr_status) begin
            v[3:0]  = lvl[3:0];
            v[15:8] = uf;
        end
        return v;
    endfunction

    task automatic apb_write(input pcm_pkg::apb_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // wait states while the fifo is full
        @(posedge clk);
        while (!pready) @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input pcm_pkg::apb_addr_t addr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // one cycle frame tick every 12 cycles
    always @(negedge clk) begin
        if (rst || zero_pause) begin
            zero     = 1'b0;
            tick_cnt = 0;
        end else if (tick_cnt == 11) begin
            zero     = 1'b1;
            tick_cnt = 0;
        end else begin
            zero     = 1'b0;
            tick_cnt = tick_cnt + 1;
        end
    end

    // reference model, decisions use the state before this edge
    always @(posedge clk) begin
        if (rst) begin
            sample_q.delete();
            prev_model = '0;
            cur_model  = '0;
            held_model = '0;
            uf_model   = '0;
            zero_q     = 1'b0;
            edge_cnt   = 0;
            delay_cnt  = 0;
            en_model  <= 1'b0;
            chk_out   <= 1'b0;
            exp_out   <= '0;
            exp_rd    <= '0;
            lvl_model <= 0;
        end else begin
            chk_out <= 1'b0;
            // read data is captured in the setup cycle
            if (psel && !penable && !pwrite) begin
                exp_rd <= read_value(paddr, en_model, sample_q.size(), uf_model);
            end
            // output moves two clocks after the edge is seen
            if (delay_cnt != 0) begin
                delay_cnt = delay_cnt - 1;
                if (delay_cnt == 0) begin
                    chk_out <= 1'b1;
                    if (edge_cnt[0] == 1'b0) begin
                        // even edge, base point and fetch
                        if (en_model && sample_q.size() != 0) begin
                            held_model = sample_q.pop_front();
                        end else if (en_model && uf_model != 8'hff) begin
                            uf_model = uf_model + 8'd1;
                        end
                        exp_out   <= cur_model;
                        prev_model = cur_model;
                        cur_model  = held_model;
                    end else begin
                        exp_out <= midpoint(prev_model, cur_model);
                    end
                end
            end
            if (zero && !zero_q) begin
                edge_cnt  = edge_cnt + 1;
                delay_cnt = 2;
            end
            zero_q = zero;
            // completed writes
            if (psel && penable && pwrite && pready) begin
                if (paddr == pcm_pkg::addr_data) begin
                    sample_q.push_back(pwdata[8:0]);
                end else if (paddr == pcm_pkg::addr_ctrl) begin
                    en_model <= pwdata[0];
                end
            end
            lvl_model <= sample_q.size();
        end
    end

    // reset values
    assert property (@(posedge clk) rst |=> (pcm_resampled == '0 && !pready && !pslverr))
        else begin
            protocol_errs++;
            $display("CHECK FAILED t=%0t %s expected 0/0/0 actual %0d/%b/%b",
                     $time, "pcm_resampled/pready/pslverr", $sampled(pcm_resampled),
                     $sampled(pready), $sampled(pslverr));
        end

    assert property (@(posedge clk) disable iff (rst) chk_out |-> pcm_resampled == exp_out)
        else begin
            value_errs++;
            $display("CHECK FAILED t=%0t pcm_resampled expected %0d actual %0d",
                     $time, $sampled(exp_out), $sampled(pcm_resampled));
        end

    assert property (@(posedge clk) disable iff (rst) !chk_out |-> $stable(pcm_resampled))
        else begin
            value_errs++;
            $display("pcm_resampled changed between updates at t=%0t", $time);
        end

    assert property (@(posedge clk) disable iff (rst) (psel && penable && !pwrite) |->
                     prdata == exp_rd)
        else begin
            value_errs++;
            $display("CHECK FAILED t=%0t prdata expected %h actual %h",
                     $time, $sampled(exp_rd), $sampled(prdata));
        end

    assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pslverr == unmapped)
        else begin
            protocol_errs++;
            $display("CHECK FAILED t=%0t pslverr expected %b actual %b",
                     $time, $sampled(unmapped), $sampled(pslverr));
        end

    // idle bus
    assert property (@(posedge clk) disable iff (rst) !(psel && penable) |-> (!pready && !pslverr))
        else begin
            protocol_errs++;
            $display("pready or pslverr high outside an access phase at t=%0t", $time);
        end

    // data writes stall exactly while the fifo is full
    assert property (@(posedge clk) disable iff (rst)
                     (psel && penable && pwrite && paddr == pcm_pkg::addr_data) |->
                     pready == (lvl_model < pcm_pkg::fifo_depth))
        else begin
            protocol_errs++;
            $display("CHECK FAILED t=%0t pready expected %b actual %b", $time,
                     $sampled(lvl_model) < pcm_pkg::fifo_depth, $sampled(pready));
        end

    assert property (@(posedge clk) disable iff (rst)
                     (psel && penable && !(pwrite && paddr == pcm_pkg::addr_data)) |-> pready)
        else begin
            protocol_errs++;
            $display("CHECK FAILED t=%0t pready expected 1 actual 0", $time);
        end

    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("timeout, the run did not end within %0d clock cycles", max_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int          i;
        logic [31:0] rnd;
        void'($urandom(82082));
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        zero_pause = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        apb_read(pcm_pkg::addr_status);
        apb_read(pcm_pkg::addr_ctrl);
        // unmapped addresses, enable must stay clear
        apb_write(8'h0c, 32'h1);
        apb_write(8'h40, 32'hffff_ffff);
        apb_read(8'h0c);
        apb_read(pcm_pkg::addr_ctrl);
        // playback off, level holds at 3
        for (i = 0; i < 3; i++) begin
            apb_write(pcm_pkg::addr_data, $urandom);
        end
        zero_pause = 1'b0;
        repeat (100) @(negedge clk);
        apb_read(pcm_pkg::addr_status);
        zero_pause = 1'b1;
        // fill to the top with extremes and small values
        apb_write(pcm_pkg::addr_ctrl, 32'h1);
        apb_read(pcm_pkg::addr_ctrl);
        apb_write(pcm_pkg::addr_data, 32'h100);
        apb_write(pcm_pkg::addr_data, 32'h0ff);
        apb_write(pcm_pkg::addr_data, 32'h1ff);
        apb_write(pcm_pkg::addr_data, 32'h001);
        apb_write(pcm_pkg::addr_data, 32'hffff_f100);
        apb_read(pcm_pkg::addr_status);
        // ninth write waits for the first pop
        fork
            apb_write(pcm_pkg::addr_data, 32'h0ff);
            begin
                repeat (40) @(negedge clk);
                zero_pause = 1'b0;
            end
        join
        for (i = 0; i < n_samples - 11; i++) begin
            rnd = $urandom;
            case (i % 4)
                0: pwdata = {rnd[31:9], 9'h100};
                1: pwdata = {rnd[31:9], 9'h0ff};
                default: pwdata = rnd;
            endcase
            apb_write(pcm_pkg::addr_data, pwdata);
            if (i % 4 == 3) begin
                apb_read(pcm_pkg::addr_status);
            end
        end
        // drain, then a few missed pops
        wait (lvl_model == 0);
        repeat (5 * 24 + 6) @(negedge clk);
        apb_read(pcm_pkg::addr_status);
        // playback off again, nothing consumed or counted
        apb_write(pcm_pkg::addr_ctrl, 32'h0);
        apb_write(pcm_pkg::addr_data, 32'h055);
        apb_write(pcm_pkg::addr_data, 32'h1aa);
        repeat (72) @(negedge clk);
        apb_read(pcm_pkg::addr_status);
        apb_read(pcm_pkg::addr_ctrl);
        repeat (4) @(negedge clk);
        $display("errors: value %0d, protocol %0d", value_errs, protocol_errs);
        if (value_errs + protocol_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: design/pcm_dac_top.sv
`timescale 1ns/10ps

module pcm_dac_top (
    input  logic                 clk,
    input  logic                 rst,
    // apb slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  pcm_pkg::apb_addr_t   paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    // synthesizer frame tick
    input  logic                 zero,
    output pcm_pkg::pcm_sample_t pcm_resampled
);

    pcm_pkg::fifo_push_t  push;
    pcm_pkg::pcm_status_t status;
    pcm_pkg::pcm_sample_t head;
    pcm_pkg::fifo_level_t level;
    logic                 full;
    logic                 empty;
    logic                 pop;
    logic                 enable;
    logic [7:0]           underflow;

    // status word for readback
    assign status = '{level: level, underflow: underflow};

    // producer, apb registers
    pcm_apb_regs u_regs (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .paddr   ( paddr   ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .pslverr ( pslverr ),
        .full    ( full    ),
        .status  ( status  ),
        .push    ( push    ),
        .enable  ( enable  )
    );

    // sample buffer
    pcm_sample_fifo u_fifo (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .push  ( push  ),
        .pop   ( pop   ),
        .head  ( head  ),
        .full  ( full  ),
        .empty ( empty ),
        .level ( level )
    );

    // consumer, up-rate stage
    pcm_uprate u_uprate (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .zero          ( zero          ),
        .enable        ( enable        ),
        .head          ( head          ),
        .empty         ( empty         ),
        .pop           ( pop           ),
        .underflow     ( underflow     ),
        .pcm_resampled ( pcm_resampled )
    );

endmodule

// File: design/pcm_uprate.sv
`timescale 1ns/10ps

module pcm_uprate (
    input  logic                 clk,
    input  logic                 rst,
    // frame tick from the synthesizer
    input  logic                 zero,
    input  logic                 enable,
    // fifo read side
    input  pcm_pkg::pcm_sample_t head,
    input  logic                 empty,
    output logic                 pop,
    // missed pops, saturating
    output logic [7:0]           underflow,
    output pcm_pkg::pcm_sample_t pcm_resampled
);

    logic last_zero;
    logic zero_edge;
    logic rate1;
    logic rate2;
    logic cen1;
    logic cen2;
    pcm_pkg::pcm_sample_t held;
    pcm_pkg::pcm_sample_t snd_in;

    // rising edge of the frame tick
    assign zero_edge = zero && !last_zero;

    // edge pipeline and divide by two
    always_ff @(posedge clk) begin
        if (rst) begin
            last_zero <= 1'b0;
            rate1     <= 1'b0;
            rate2     <= 1'b0;
            cen1      <= 1'b0;
            cen2      <= 1'b0;
        end else begin
            last_zero <= zero;
            rate1     <= zero_edge;
            if (zero_edge) begin
                rate2 <= ~rate2;
            end
            cen1 <= rate1;
            // every second edge, the first one after reset is skipped
            cen2 <= rate1 && !rate2;
        end
    end

    // fetch a new sample once per input period
    assign pop = cen2 && enable && !empty;

    // repeat the last sample when nothing was popped
    assign snd_in = pop ? head : held;

    always_ff @(posedge clk) begin
        if (rst) begin
            held      <= '0;
            underflow <= '0;
        end else begin
            if (pop) begin
                held <= head;
            end
            // count a miss only while playback is enabled
            if (cen2 && enable && empty && underflow != 8'hff) begin
                underflow <= underflow + 8'd1;
            end
        end
    end

    // x2 interpolator
    pcm_interpol u_interpol (
        .clk     ( clk           ),
        .rst     ( rst           ),
        .cen_in  ( cen2          ),
        .cen_out ( cen1          ),
        .snd_in  ( snd_in        ),
        .snd_out ( pcm_resampled )
    );

endmodule

// File: design/pcm_interpol.sv
`timescale 1ns/10ps

module pcm_interpol (
    input  logic                 clk,
    input  logic                 rst,
    // input sample strobe, slow rate
    input  logic                 cen_in,
    // output sample strobe, twice the input rate
    input  logic                 cen_out,
    input  pcm_pkg::pcm_sample_t snd_in,
    output pcm_pkg::pcm_sample_t snd_out
);

    // two most recent input samples
    pcm_pkg::pcm_sample_t prev;
    pcm_pkg::pcm_sample_t cur;

    // where we are inside one input period
    pcm_pkg::uprate_phase_t phase;

    // midpoint arithmetic
    pcm_pkg::pcm_calc_t sum;
    pcm_pkg::pcm_calc_t half;

    // sign extended sum, 10 bits hold it without overflow
    assign sum = pcm_pkg::pcm_calc_t'(prev) + pcm_pkg::pcm_calc_t'(cur);

    // arithmetic shift, rounds toward minus infinity
    assign half = sum >>> 1;

    // sample history, cleared so the first midpoint is defined
    always_ff @(posedge clk) begin
        if (rst) begin
            prev <= '0;
            cur  <= '0;
        end else if (cen_in) begin
            prev <= cur;
            cur  <= snd_in;
        end
    end

    // output register and phase
    always_ff @(posedge clk) begin
        if (rst) begin
            snd_out <= '0;
            phase   <= pcm_pkg::phase_base;
        end else if (cen_in) begin
            // base point is the sample that was current until now
            snd_out <= cur;
            phase   <= pcm_pkg::phase_base;
        end else if (cen_out) begin
            // halfway between the two stored samples
            // half always fits in 9 bits
            snd_out <= half[8:0];
            phase   <= pcm_pkg::phase_mid;
        end
    end

    // input strobe is a subset of the output strobe
    assert property (@(posedge clk) disable iff (rst) cen_in |-> cen_out)
        else $error("cen_in without cen_out");

    // base and midpoint alternate, no two midpoints back to back
    assert property (@(posedge clk) disable iff (rst)
                     (cen_out && !cen_in) |-> (phase == pcm_pkg::phase_base))
        else $error("two midpoints without a new input sample");

endmodule

// File: design/pcm_sample_fifo.sv
`timescale 1ns/10ps

module pcm_sample_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  pcm_pkg::fifo_push_t  push,
    input  logic                 pop,
    output pcm_pkg::pcm_sample_t head,
    output logic                 full,
    output logic                 empty,
    output pcm_pkg::fifo_level_t level
);

    // sample storage
    pcm_pkg::pcm_sample_t mem [pcm_pkg::fifo_depth];

    // circular pointers, depth is a power of two so they wrap by themselves
    logic [$clog2(pcm_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(pcm_pkg::fifo_depth)-1:0] rd_ptr;

    // flags straight from the level count
    assign full  = (level == pcm_pkg::fifo_level_t'(pcm_pkg::fifo_depth));
    assign empty = (level == '0);

    // oldest sample is always visible
    assign head = mem[rd_ptr];

    // storage write, no reset
    always_ff @(posedge clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.sample;
        end
    end

    // pointers and level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together keep the level
            case ({push.valid, pop})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // the up-rate stage must check empty before popping
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop from an empty sample fifo");

    // register block must stall writes on full
    assert property (@(posedge clk) disable iff (rst) push.valid |-> !full)
        else $error("push into a full sample fifo");

    // level never exceeds the depth
    assert property (@(posedge clk) disable iff (rst)
                     level <= pcm_pkg::fifo_level_t'(pcm_pkg::fifo_depth))
        else $error("fifo level out of range");

endmodule

// File: design/pcm_apb_regs.sv
`timescale 1ns/10ps

module pcm_apb_regs (
    input  logic                 clk,
    input  logic                 rst,
    // apb slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  pcm_pkg::apb_addr_t   paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    // fifo side
    input  logic                 full,
    input  pcm_pkg::pcm_status_t status,
    output pcm_pkg::fifo_push_t  push,
    // control
    output logic                 enable
);

    logic setup_phase;
    logic access_phase;
    logic addr_hit;
    logic data_wr;
    logic wait_state;
    logic xfer_done;
    logic [31:0] rd_mux;

    // apb phases
    assign setup_phase  = psel && !penable;
    assign access_phase = psel && penable;

    // only three registers are mapped
    assign addr_hit = (paddr == pcm_pkg::addr_ctrl) ||
                      (paddr == pcm_pkg::addr_data) ||
                      (paddr == pcm_pkg::addr_status);

    // write to the sample register
    assign data_wr = access_phase && pwrite && (paddr == pcm_pkg::addr_data);

    // stall the master while the fifo has no room
    assign wait_state = data_wr && full;

    // pready low outside access phases
    assign pready  = access_phase && !wait_state;
    assign pslverr = access_phase && !addr_hit;

    // last cycle of a transfer
    assign xfer_done = access_phase && pready;

    // push on the completing access cycle only
    // bits above 8 of pwdata are dropped
    assign push.valid  = data_wr && !full;
    assign push.sample = pwdata[8:0];

    // read mux, sampled during setup
    always_comb begin
        rd_mux = 32'd0;
        case (paddr)
            pcm_pkg::addr_ctrl: begin
                rd_mux[0] = enable;
            end
            pcm_pkg::addr_status: begin
                rd_mux[3:0]  = status.level;
                rd_mux[15:8] = status.underflow;
            end
            default: begin
                // data register is write only, unmapped reads as zero
                rd_mux = 32'd0;
            end
        endcase
    end

    // registered read data, valid in the access cycle
    always_ff @(posedge clk) begin
        if (setup_phase && !pwrite) begin
            prdata <= rd_mux;
        end
    end

    // control register
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
        end else if (xfer_done && pwrite && paddr == pcm_pkg::addr_ctrl) begin
            enable <= pwdata[0];
        end
    end

    // one push per transfer, the master drops penable after pready
    assert property (@(posedge clk) disable iff (rst) push.valid |=> !push.valid)
        else $error("one apb transfer pushed two samples");

    // a stalled data write keeps its address and data until it completes
    assert property (@(posedge clk) disable iff (rst)
                     wait_state |=> (data_wr && $stable(pwdata)))
        else $error("stalled data write changed before completion");

endmodule

// File: design/pcm_pkg.sv
package pcm_pkg;

    // signed 9-bit pcm sample as written over apb
    typedef logic signed [8:0] pcm_sample_t;

    // interpolator working width
    // one extra bit so the sum of two samples cannot overflow
    typedef logic signed [9:0] pcm_calc_t;

    // sample fifo
    localparam int fifo_depth = 8;

    // fill level, 0 up to fifo_depth inclusive
    typedef logic [3:0] fifo_level_t;

    // apb register map
    typedef logic [7:0] apb_addr_t;

    localparam apb_addr_t addr_ctrl   = 8'h00;
    localparam apb_addr_t addr_data   = 8'h04;
    localparam apb_addr_t addr_status = 8'h08;

    // position of the x2 interpolator inside one input period
    typedef enum logic {
        phase_base,
        phase_mid
    } uprate_phase_t;

    // write port from the register block into the fifo
    typedef struct packed {
        logic        valid;
        pcm_sample_t sample;
    } fifo_push_t;

    // status word, read back through addr_status
    typedef struct packed {
        fifo_level_t level;
        // saturating count of missed pops
        logic [7:0]  underflow;
    } pcm_status_t;

endpackage
